/* files.f */
verilog/rename_pkg.sv
verilog/retire_forward.sv
verilog/tag_cam.sv
verilog/arch_map_table.sv
verilog/freed_reg_packer.sv
verilog/retire_map_top.sv
sim/retire_map_tb.sv

/* sim/retire_map_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_map_tb;
	import rename_pkg::*;

	localparam int SS_SIZE      = 3;
	localparam int NUM_ARCH_REG = 32;
	localparam int CNT_W        = $clog2(SS_SIZE + 1);

	// Reset 8, reset map 1, single lane 4, full group 2, chains 3, sparse 6, stream 301
	localparam int TEST_CYCLES    = 8 + 1 + 4 + 2 + 3 + 6 + 301;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

	typedef logic [CNT_W-1:0] count_t;

	logic               clock;
	logic               reset;
	logic [SS_SIZE-1:0] retire_enable;
	phys_reg_t          retire_t_new [SS_SIZE];
	phys_reg_t          retire_t_old [SS_SIZE];
	phys_reg_t          arch_map     [NUM_ARCH_REG];
	phys_reg_t          freed_tag    [SS_SIZE];
	count_t             freed_count;

	// Reference model state
	phys_reg_t model_map [NUM_ARCH_REG];
	phys_reg_t free_pool [$];

	// Expected outputs for the group driven on the previous edge
	phys_reg_t pending_map [NUM_ARCH_REG];
	phys_reg_t pending_tag [SS_SIZE];
	count_t    pending_count;

	// Group under construction
	logic [SS_SIZE-1:0] grp_en;
	arch_reg_t          grp_dst [SS_SIZE];

	int error_count = 0;
	int cycle_count = 0;

	retire_map_top u_dut (
		.clock         (clock),
		.reset         (reset),
		.retire_enable (retire_enable),
		.retire_t_new  (retire_t_new),
		.retire_t_old  (retire_t_old),
		.arch_map      (arch_map),
		.freed_tag     (freed_tag),
		.freed_count   (freed_count)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("Checks failed");
		$fatal(1, "%s", reason);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("simulation timed out after %0d cycles", cycle_count));
		end
	end

	task automatic check_map(input arch_reg_t idx, input phys_reg_t got,
			input phys_reg_t exp);
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t: arch_map[%0d] is %0d, expected %0d",
				$time, idx, got, exp);
			abort_run("first error reached");
		end
	endtask

	task automatic check_freed(input count_t got_count, input count_t exp_count,
			input phys_reg_t got_tag [SS_SIZE], input phys_reg_t exp_tag [SS_SIZE]);
		if (got_count !== exp_count) begin
			error_count++;
			$display("mismatch at %0t: freed_count is %0d, expected %0d",
				$time, got_count, exp_count);
			abort_run("first error reached");
		end
		for (int j = 0; j < SS_SIZE; j++) begin
			// Lanes above the count are free
			if (j < exp_count && got_tag[j] !== exp_tag[j]) begin
				error_count++;
				$display("mismatch at %0t: freed_tag[%0d] is %0d, expected %0d",
					$time, j, got_tag[j], exp_tag[j]);
				abort_run("first error reached");
			end
		end
	endtask

	task automatic check_outputs();
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			check_map(arch_reg_t'(i), arch_map[i], pending_map[i]);
		end
		check_freed(freed_count, pending_count, freed_tag, pending_tag);
	endtask

	// Identity mapping, spare tags go to the pool
	task automatic init_model();
		free_pool.delete();
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			model_map[i] = phys_reg_t'(i);
		end
		for (int t = NUM_ARCH_REG; t < NUM_PHYS_REG; t++) begin
			free_pool.push_back(phys_reg_t'(t));
		end
		pending_map   = model_map;
		pending_count = '0;
		for (int j = 0; j < SS_SIZE; j++) begin
			pending_tag[j] = DUMMY_REG;
		end
		grp_en = '0;
	endtask

	task automatic set_lane(input int lane, input int dst);
		grp_en[lane]  = 1'b1;
		grp_dst[lane] = arch_reg_t'(dst);
	endtask

	// Build a legal group from the model, drive it, and check the previous group
	task automatic drive_cycle();
		phys_reg_t t_new   [SS_SIZE];
		phys_reg_t t_old   [SS_SIZE];
		phys_reg_t exp_tag [SS_SIZE];
		int        n;

		n = 0;
		for (int j = 0; j < SS_SIZE; j++) begin
			t_new[j]   = DUMMY_REG;
			t_old[j]   = DUMMY_REG;
			exp_tag[j] = DUMMY_REG;
		end
		for (int j = 0; j < SS_SIZE; j++) begin
			if (grp_en[j]) begin
				t_old[j]              = model_map[grp_dst[j]];   // Running map, in lane order
				t_new[j]              = free_pool.pop_front();
				model_map[grp_dst[j]] = t_new[j];
				exp_tag[n]            = t_old[j];
				n++;
			end
		end
		for (int j = 0; j < n; j++) begin
			free_pool.push_back(exp_tag[j]);
		end

		@(posedge clock);
		retire_enable <= grp_en;
		for (int j = 0; j < SS_SIZE; j++) begin
			retire_t_new[j] <= t_new[j];
			retire_t_old[j] <= t_old[j];
		end

		@(negedge clock);
		check_outputs();
		pending_map   = model_map;
		pending_tag   = exp_tag;
		pending_count = count_t'(n);
		grp_en        = '0;
	endtask

	task automatic idle_cycle();
		grp_en = '0;
		drive_cycle();
	endtask

	task automatic test_reset_mapping();
		@(negedge clock);
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			check_map(arch_reg_t'(i), arch_map[i], phys_reg_t'(i));
		end
		check_freed(freed_count, count_t'(0), freed_tag, pending_tag);
	endtask

	task automatic test_single_lane();
		for (int lane = 0; lane < SS_SIZE; lane++) begin
			set_lane(lane, lane * 5 + 1);
			drive_cycle();
		end
		idle_cycle();
	endtask

	task automatic test_full_group();
		set_lane(0, 3);
		set_lane(1, 7);
		set_lane(2, 12);
		drive_cycle();
		idle_cycle();
	endtask

	task automatic test_chains();
		set_lane(0, 9);   // Two-lane chain
		set_lane(1, 9);
		set_lane(2, 4);
		drive_cycle();
		set_lane(0, 20);   // Three-lane chain
		set_lane(1, 20);
		set_lane(2, 20);
		drive_cycle();
		idle_cycle();
	endtask

	task automatic test_sparse();
		set_lane(0, 2);
		set_lane(2, 30);
		drive_cycle();
		idle_cycle();
		set_lane(1, 14);
		drive_cycle();
		set_lane(1, 17);
		set_lane(2, 17);
		drive_cycle();
		set_lane(0, 5);   // Chain across a disabled lane
		set_lane(2, 5);
		drive_cycle();
		idle_cycle();
	endtask

	task automatic test_random_stream();
		for (int n = 0; n < 300; n++) begin
			for (int j = 0; j < SS_SIZE; j++) begin
				grp_en[j]  = 1'($urandom_range(0, 1));
				grp_dst[j] = arch_reg_t'($urandom_range(0, NUM_ARCH_REG - 1));
			end
			drive_cycle();
		end
		idle_cycle();
	endtask

	initial begin
		void'($urandom(32'h26d88847));
		reset         = 1'b1;
		retire_enable = '0;
		for (int j = 0; j < SS_SIZE; j++) begin
			retire_t_new[j] = DUMMY_REG;
			retire_t_old[j] = DUMMY_REG;
		end
		init_model();

		repeat (8) @(posedge clock);
		reset <= 1'b0;

		test_reset_mapping();
		test_single_lane();
		test_full_group();
		test_chains();
		test_sparse();
		test_random_stream();

		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/arch_map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_map_table #(
	parameter int NUM_ARCH_REG = 32,
	parameter int SS_SIZE      = 3
) (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic [SS_SIZE-1:0]    fwd_enable,
	input  wire rename_pkg::phys_reg_t fwd_t_new [SS_SIZE],
	input  wire rename_pkg::phys_reg_t fwd_t_old [SS_SIZE],
	output rename_pkg::phys_reg_t      arch_map [NUM_ARCH_REG]
);
	import rename_pkg::*;

	phys_reg_t          map_next  [NUM_ARCH_REG];
	phys_reg_t          cam_table [NUM_ARCH_REG];
	phys_reg_t          cam_tags  [SS_SIZE];
	logic [SS_SIZE-1:0] cam_hits  [NUM_ARCH_REG];

	// Per lane view of the hits, for the checks below
	logic [NUM_ARCH_REG-1:0] lane_hits [SS_SIZE];

	// Reset mapping needs a tag per register, and register indices must fit
	if (NUM_ARCH_REG > NUM_PHYS_REG || NUM_ARCH_REG > (1 << ARCH_IDX_W)) begin : g_size_chk
		$error("NUM_ARCH_REG %0d does not fit the tag widths", NUM_ARCH_REG);
	end

	assign cam_table = arch_map;
	assign cam_tags  = fwd_t_old;

	// Find the entry currently holding each forwarded T_old
	tag_cam #(
		.LENGTH   (NUM_ARCH_REG),
		.NUM_TAGS (SS_SIZE)
	) u_cam (
		.enable   (fwd_enable),
		.tags     (cam_tags),
		.table_in (cam_table),
		.hits     (cam_hits)
	);

	always_comb begin
		map_next = arch_map;
		for (int i = 0; i < NUM_ARCH_REG; i++) begin
			for (int j = 0; j < SS_SIZE; j++) begin
				if (cam_hits[i][j]) begin
					map_next[i] = fwd_t_new[j];   // At most one lane per entry
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH_REG; i++) begin
				arch_map[i] <= phys_reg_t'(i);   // Register i starts in tag i
			end
		end else begin
			arch_map <= map_next;
		end
	end

	always_comb begin
		for (int j = 0; j < SS_SIZE; j++) begin
			for (int i = 0; i < NUM_ARCH_REG; i++) begin
				lane_hits[j][i] = cam_hits[i][j];
			end
		end
	end

	// Each surviving lane lands on exactly one entry
	for (genvar j = 0; j < SS_SIZE; j++) begin : g_lane_chk
		a_one_entry: assert property (@(posedge clock) disable iff (reset)
			fwd_enable[j] |-> $onehot(lane_hits[j]))
			else $error("lane %0d T_old %0d not held by exactly one entry", j, fwd_t_old[j]);
	end

	// Forwarding must leave no two lanes on the same entry
	for (genvar i = 0; i < NUM_ARCH_REG; i++) begin : g_entry_chk
		a_single_writer: assert property (@(posedge clock) disable iff (reset)
			$onehot0(cam_hits[i]))
			else $error("entry %0d hit by several lanes", i);
	end

endmodule

`default_nettype wire

/* verilog/freed_reg_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module freed_reg_packer #(
	parameter int SS_SIZE = 3
) (
	input  wire logic                    clock,
	input  wire logic                    reset,
	input  wire logic [SS_SIZE-1:0]      retire_enable,
	input  wire rename_pkg::phys_reg_t   retire_t_old [SS_SIZE],
	output rename_pkg::phys_reg_t        freed_tag [SS_SIZE],
	output logic [$clog2(SS_SIZE+1)-1:0] freed_count
);
	import rename_pkg::*;

	localparam int CNT_W = $clog2(SS_SIZE + 1);

	phys_reg_t        pack_tag [SS_SIZE];
	logic [CNT_W-1:0] pack_count;

	// Compact the enabled T_old tags into the low lanes, oldest first.
	// Every retiring lane frees its own T_old, merged or not
	always_comb begin
		pack_count = '0;
		for (int j = 0; j < SS_SIZE; j++) begin
			pack_tag[j] = DUMMY_REG;   // Don't care above the count
		end
		for (int j = 0; j < SS_SIZE; j++) begin
			if (retire_enable[j]) begin
				pack_tag[pack_count] = retire_t_old[j];
				pack_count           = pack_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		freed_tag <= pack_tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			freed_count <= '0;
		end else begin
			freed_count <= pack_count;   // Valid for this cycle only
		end
	end

	a_count_range: assert property (@(posedge clock) disable iff (reset)
		freed_count <= SS_SIZE)
		else $error("freed_count %0d exceeds %0d lanes", freed_count, SS_SIZE);

endmodule

`default_nettype wire

/* verilog/rename_pkg.sv */
`default_nettype none

package rename_pkg;

	// Physical register file
	localparam int PHYS_IDX_W   = 6;
	localparam int NUM_PHYS_REG = 64;

	// Architectural register index
	localparam int ARCH_IDX_W = 5;

	typedef logic [PHYS_IDX_W-1:0] phys_reg_t;   // One physical tag
	typedef logic [ARCH_IDX_W-1:0] arch_reg_t;   // One architectural register

	// Filler tag for lanes that carry no update
	localparam phys_reg_t DUMMY_REG = '0;

endpackage

`default_nettype wire

/* verilog/retire_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_forward #(
	parameter int SS_SIZE = 3
) (
	input  wire logic [SS_SIZE-1:0]   retire_enable,
	input  wire rename_pkg::phys_reg_t retire_t_new [SS_SIZE],
	input  wire rename_pkg::phys_reg_t retire_t_old [SS_SIZE],
	output logic [SS_SIZE-1:0]        fwd_enable,
	output rename_pkg::phys_reg_t     fwd_t_new [SS_SIZE],
	output rename_pkg::phys_reg_t     fwd_t_old [SS_SIZE]
);
	import rename_pkg::*;

	// Lane j folded into a later lane that renames the same register
	logic [SS_SIZE-1:0] merged;

	// T_old after inheritance along a rename chain
	phys_reg_t eff_old [SS_SIZE];

	// Walk the lanes oldest first. A younger lane whose T_old is the T_new of
	// an older lane takes over the older lane's entry, so the older lane is
	// dropped and its own (possibly inherited) T_old moves forward. Because
	// eff_old of the older lane is final by the time it is visited, chains of
	// any length collapse onto the youngest lane in one pass.
	always_comb begin
		merged = '0;
		for (int j = 0; j < SS_SIZE; j++) begin
			eff_old[j] = retire_t_old[j];
		end

		for (int j = 0; j < SS_SIZE; j++) begin
			for (int k = j + 1; k < SS_SIZE; k++) begin
				if (retire_enable[j] && retire_enable[k] && !merged[j] &&
						(retire_t_old[k] == retire_t_new[j])) begin
					merged[j]  = 1'b1;
					eff_old[k] = eff_old[j];   // Younger lane inherits the entry
				end
			end
		end
	end

	// Surviving lanes touch distinct entries and can be written in parallel
	always_comb begin
		for (int j = 0; j < SS_SIZE; j++) begin
			fwd_enable[j] = retire_enable[j] & ~merged[j];
			if (fwd_enable[j]) begin
				fwd_t_new[j] = retire_t_new[j];
				fwd_t_old[j] = eff_old[j];
			end else begin
				fwd_t_new[j] = DUMMY_REG;
				fwd_t_old[j] = DUMMY_REG;
			end
		end
	end

	// A lane that renames a tag onto itself would make the chain walk loop
	// back on its own entry and corrupt the inherited T_old
	for (genvar g = 0; g < SS_SIZE; g++) begin : g_lane_chk
		always_comb begin
			if (retire_enable[g]) begin
				a_no_self_rename: assert final (retire_t_old[g] != retire_t_new[g])
					else $error("retire lane %0d renames tag %0d onto itself",
						g, retire_t_new[g]);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/retire_map_top.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_map_top #(
	parameter int SS_SIZE      = 3,
	parameter int NUM_ARCH_REG = 32
) (
	input  wire logic                    clock,
	input  wire logic                    reset,
	input  wire logic [SS_SIZE-1:0]      retire_enable,
	input  wire rename_pkg::phys_reg_t   retire_t_new [SS_SIZE],
	input  wire rename_pkg::phys_reg_t   retire_t_old [SS_SIZE],
	output rename_pkg::phys_reg_t        arch_map  [NUM_ARCH_REG],
	output rename_pkg::phys_reg_t        freed_tag [SS_SIZE],
	output logic [$clog2(SS_SIZE+1)-1:0] freed_count
);
	import rename_pkg::*;

	// Collapsed retire group
	logic [SS_SIZE-1:0] fwd_enable;
	phys_reg_t          fwd_t_new [SS_SIZE];
	phys_reg_t          fwd_t_old [SS_SIZE];

	retire_forward #(
		.SS_SIZE (SS_SIZE)
	) u_forward (
		.retire_enable (retire_enable),
		.retire_t_new  (retire_t_new),
		.retire_t_old  (retire_t_old),
		.fwd_enable    (fwd_enable),
		.fwd_t_new     (fwd_t_new),
		.fwd_t_old     (fwd_t_old)
	);

	arch_map_table #(
		.NUM_ARCH_REG (NUM_ARCH_REG),
		.SS_SIZE      (SS_SIZE)
	) u_map (
		.clock      (clock),
		.reset      (reset),
		.fwd_enable (fwd_enable),
		.fwd_t_new  (fwd_t_new),
		.fwd_t_old  (fwd_t_old),
		.arch_map   (arch_map)
	);

	// Freed list comes from the raw lanes, not the forwarded ones
	freed_reg_packer #(
		.SS_SIZE (SS_SIZE)
	) u_packer (
		.clock         (clock),
		.reset         (reset),
		.retire_enable (retire_enable),
		.retire_t_old  (retire_t_old),
		.freed_tag     (freed_tag),
		.freed_count   (freed_count)
	);

endmodule

`default_nettype wire

/* verilog/tag_cam.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_cam #(
	parameter int LENGTH   = 32,
	parameter int NUM_TAGS = 3
) (
	input  wire logic [NUM_TAGS-1:0]   enable,
	input  wire rename_pkg::phys_reg_t tags [NUM_TAGS],
	input  wire rename_pkg::phys_reg_t table_in [LENGTH],
	output logic [NUM_TAGS-1:0]        hits [LENGTH]
);

	// Every entry compared against every search lane in parallel
	always_comb begin
		for (int i = 0; i < LENGTH; i++) begin
			for (int j = 0; j < NUM_TAGS; j++) begin
				hits[i][j] = enable[j] && (table_in[i] == tags[j]);   // Idle lanes never hit
			end
		end
	end

endmodule

`default_nettype wire
